//--- id_stimulus.txt
// instr    pc       fu op rd rs1 rs2 imm      ctrl_flow illegal
// fu and op use the decode package encodings, compressed words have a zero upper half
002081B3 00001000 1 00 03 01 02 00000000 0 0
407302B3 00001004 1 01 05 06 07 00000000 0 0
FFB00513 00001008 1 00 0A 00 00 FFFFFFFB 0 0
40325213 0000100C 1 07 04 04 00 00000403 0 0
123453B7 00001010 1 0A 07 00 00 12345000 0 0
00001417 00001014 1 0B 08 00 00 00001000 0 0
010000EF 00001018 2 0C 01 00 00 00000010 1 0
00008067 0000101C 2 0D 00 01 00 00000000 1 0
FE208CE3 00001020 2 0E 00 01 02 FFFFFFF8 1 0
00C12483 00001024 3 14 09 02 00 0000000C 0 0
00912A23 00001028 3 15 00 02 09 00000014 0 0
0000000B 0000102C 0 00 00 00 00 00000000 0 1
00004595 00001030 1 00 0B 00 00 00000005 0 0
00009426 00001032 1 00 08 08 09 00000000 0 0
00004144 00001034 3 14 09 0A 00 00000004 0 0
0000C401 00001036 2 0E 00 08 00 00000008 1 0
00000000 00001038 0 00 00 00 00 00000000 0 1

//--- vlog.f
decode_pkg.sv
decode_lane_if.sv
rvc_expander.sv
instr_decoder.sv
issue_register.sv
id_stage.sv
id_stage_assertions.sv
id_stage_checker.sv
tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o sim_tb_id_stage
./obj_dir/sim_tb_id_stage | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failure"

//--- tb_id_stage.sv
// Testbench for the instruction decode stage
// Drives file stimulus on both fetch lanes with random issue acknowledge

`timescale 1ns/1ns

module tb_id_stage;
  import decode_pkg::*;

  localparam int unsigned NUM_INSTR     = 17;
  localparam int unsigned NUM_FIELDS    = 10;
  localparam int unsigned FLUSH_IDX     = 8;
  localparam int unsigned READY_TIMEOUT = 20;
  localparam int unsigned RUN_TIMEOUT   = 400;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          flush_i;
  logic [NR_LANES-1:0][XLEN-1:0] fetch_instr_i;
  logic [NR_LANES-1:0][XLEN-1:0] fetch_pc_i;
  logic [NR_LANES-1:0]           fetch_valid_i;
  logic [NR_LANES-1:0]           fetch_ready_o;
  logic [NR_LANES-1:0]           issue_ack_i;
  logic [NR_LANES-1:0]           issue_valid_o;
  issue_entry_t [NR_LANES-1:0]   issue_entry_o;
  logic [NR_LANES-1:0][XLEN-1:0] orig_instr_o;
  logic [NR_LANES-1:0]           is_ctrl_flow_o;

  logic [31:0]  stim_mem [NUM_INSTR*NUM_FIELDS];
  int           seed;
  int unsigned  idx;
  int unsigned  cycles;
  int unsigned  timeouts;
  int unsigned  issued_cnt;
  int unsigned  flushed_cnt;
  int unsigned  err_cnt;
  logic         flush_done;

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  id_stage u_id_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_pc_i     (fetch_pc_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .issue_ack_i    (issue_ack_i),
    .issue_valid_o  (issue_valid_o),
    .issue_entry_o  (issue_entry_o),
    .orig_instr_o   (orig_instr_o),
    .is_ctrl_flow_o (is_ctrl_flow_o)
  );

  id_stage_checker #(
    .NUM_INSTR  (NUM_INSTR),
    .NUM_FIELDS (NUM_FIELDS)
  ) u_id_stage_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_i  (fetch_ready_o),
    .issue_ack_i    (issue_ack_i),
    .issue_entry_i  (issue_entry_o),
    .orig_instr_i   (orig_instr_o),
    .is_ctrl_flow_i (is_ctrl_flow_o),
    .stim_i         (stim_mem),
    .issued_o       (issued_cnt),
    .flushed_o      (flushed_cnt),
    .errors_o       (err_cnt)
  );

  // One falling-edge update of fetch, acknowledge and flush
  task automatic drive_inputs();
    int r;
    r       = $random(seed);
    flush_i = 1'b0;
    // Flush only while an entry waits, so something is really discarded
    if (!flush_done && idx >= FLUSH_IDX && issue_valid_o[0]) begin
      flush_i    = 1'b1;
      flush_done = 1'b1;
    end
    for (int unsigned k = 0; k < NR_LANES; k++) begin
      if (idx + k < NUM_INSTR) begin
        fetch_instr_i[k] = stim_mem[(idx + k) * NUM_FIELDS];
        fetch_pc_i[k]    = stim_mem[(idx + k) * NUM_FIELDS + 1];
      end else begin
        fetch_instr_i[k] = '0;
        fetch_pc_i[k]    = '0;
      end
    end
    // Lane 1 only ever offered together with lane 0
    fetch_valid_i[0] = (idx < NUM_INSTR);
    fetch_valid_i[1] = (idx + 1 < NUM_INSTR) && r[0];
    // In-order acknowledge, slot 1 only along with slot 0
    issue_ack_i[0] = issue_valid_o[0] && !flush_i && (r[2:1] != 2'b00);
    issue_ack_i[1] = issue_ack_i[0] && issue_valid_o[1] && r[3];
  endtask

  initial begin
    seed          = 62;
    idx           = 0;
    timeouts      = 0;
    flush_done    = 1'b0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    fetch_valid_i = '0;
    issue_ack_i   = '0;
    $readmemh("id_stimulus.txt", stim_mem);

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    cycles = 0;
    while (fetch_ready_o != 2'b11 && cycles < READY_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (fetch_ready_o != 2'b11) begin
      timeouts++;
      $display("Timeout: fetch_ready_o did not rise after reset");
    end

    cycles = 0;
    while (timeouts == 0 && issued_cnt + flushed_cnt < NUM_INSTR) begin
      @(negedge clk_i);
      drive_inputs();
      @(posedge clk_i);
      idx += 32'(fetch_valid_i[0] & fetch_ready_o[0]) + 32'(fetch_valid_i[1] & fetch_ready_o[1]);
      cycles++;
      if (cycles >= RUN_TIMEOUT) begin
        timeouts++;
        $display("Timeout: only %0d of %0d instructions left the stage",
                 issued_cnt + flushed_cnt, NUM_INSTR);
      end
    end

    @(negedge clk_i);
    fetch_valid_i = '0;
    issue_ack_i   = '0;
    $display("Done: %0d issued, %0d flushed, %0d errors, %0d timeouts",
             issued_cnt, flushed_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- id_stage_checker.sv
// Decode stage checker
// Tracks accepted words in program order and compares issued entries

`timescale 1ns/1ns

module id_stage_checker #(
  parameter int unsigned NUM_INSTR  = 1,
  parameter int unsigned NUM_FIELDS = 10
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  flush_i,
  input  logic [decode_pkg::NR_LANES-1:0]                       fetch_valid_i,
  input  logic [decode_pkg::NR_LANES-1:0]                       fetch_ready_i,
  input  logic [decode_pkg::NR_LANES-1:0]                       issue_ack_i,
  input  decode_pkg::issue_entry_t [decode_pkg::NR_LANES-1:0]   issue_entry_i,
  input  logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0] orig_instr_i,
  input  logic [decode_pkg::NR_LANES-1:0]                       is_ctrl_flow_i,
  input  logic [31:0]                                           stim_i [NUM_INSTR*NUM_FIELDS],
  output int unsigned                                           issued_o,
  output int unsigned                                           flushed_o,
  output int unsigned                                           errors_o
);
  import decode_pkg::*;

  // File indices of words that sit in the issue slots, oldest first
  int unsigned pending [$];
  int unsigned accept_cnt = 0;
  int unsigned issued     = 0;
  int unsigned flushed    = 0;
  int unsigned errors     = 0;

  task automatic compare_field(input int unsigned n, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: instruction %0d field %s is %h, expected %h",
               $time, n, name, got, exp);
    end
  endtask

  task automatic check_slot(input int slot, input issue_entry_t e,
                            input logic [31:0] orig, input logic cf);
    int unsigned n;
    int unsigned b;
    logic [31:0] word;
    logic        comp;
    if (pending.size() == 0) begin
      errors++;
      $display("Slot %0d was acknowledged with no instruction outstanding", slot);
    end else begin
      n    = pending.pop_front();
      b    = n * NUM_FIELDS;
      word = stim_i[b];
      comp = (word[1:0] != 2'b11);
      compare_field(n, "pc", e.pc, stim_i[b+1]);
      compare_field(n, "fu", 32'(e.fu), stim_i[b+2]);
      compare_field(n, "op", 32'(e.op), stim_i[b+3]);
      compare_field(n, "rd", 32'(e.rd), stim_i[b+4]);
      compare_field(n, "rs1", 32'(e.rs1), stim_i[b+5]);
      compare_field(n, "rs2", 32'(e.rs2), stim_i[b+6]);
      compare_field(n, "imm", e.imm, stim_i[b+7]);
      compare_field(n, "is_ctrl_flow", 32'(cf), stim_i[b+8]);
      compare_field(n, "illegal", 32'(e.illegal), stim_i[b+9]);
      compare_field(n, "is_compressed", 32'(e.is_compressed), 32'(comp));
      // Compressed words keep only their own 16 bits
      compare_field(n, "orig_instr", orig, comp ? {16'b0, word[15:0]} : word);
      issued++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (issue_ack_i[0]) begin
        check_slot(0, issue_entry_i[0], orig_instr_i[0], is_ctrl_flow_i[0]);
      end
      if (issue_ack_i[1]) begin
        check_slot(1, issue_entry_i[1], orig_instr_i[1], is_ctrl_flow_i[1]);
      end
      // A flush drops whatever was not acknowledged in this cycle
      if (flush_i) begin
        flushed += pending.size();
        pending.delete();
      end
      for (int unsigned k = 0; k < NR_LANES; k++) begin
        if (fetch_valid_i[k] && fetch_ready_i[k]) begin
          pending.push_back(accept_cnt);
          accept_cnt++;
        end
      end
    end
    issued_o  <= issued;
    flushed_o <= flushed;
    errors_o  <= errors;
  end

endmodule

//--- id_stage_assertions.sv
// Handshake and reset properties of the ID/issue register

`timescale 1ns/1ns

module id_stage_assertions (
  input logic                                                clk_i,
  input logic                                                rst_ni,
  input logic                                                flush_i,
  input logic [decode_pkg::NR_LANES-1:0]                     issue_valid_i,
  input logic [decode_pkg::NR_LANES-1:0]                     issue_ack_i,
  input decode_pkg::issue_entry_t [decode_pkg::NR_LANES-1:0] issue_entry_i
);

  valid_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> issue_valid_i == '0)
    else $error("issue_valid_o is high while reset is asserted");

  ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_ack_i & ~issue_valid_i) == '0)
    else $error("issue_ack_i raised for a slot that is not valid");

  // A held entry keeps its slot and its contents
  slot0_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i[0] && !issue_ack_i[0] && !flush_i |=>
      issue_valid_i[0] && $stable(issue_entry_i[0]))
    else $error("Unacknowledged entry in slot 0 changed");

  slot1_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i[1] && issue_ack_i == '0 && !flush_i |=>
      issue_valid_i[1] && $stable(issue_entry_i[1]))
    else $error("Unacknowledged entry in slot 1 changed");

endmodule

bind issue_register id_stage_assertions u_id_stage_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .flush_i       (flush_i),
  .issue_valid_i (issue_valid_o),
  .issue_ack_i   (issue_ack_i),
  .issue_entry_i (issue_entry_o)
);

//--- id_stage.sv
// Instruction decode stage for a dual-issue RV32 core
// Expands compressed words, decodes both lanes and holds them for issue

`timescale 1ns/1ns

module id_stage (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   flush_i,
  input  logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0]  fetch_instr_i,
  input  logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0]  fetch_pc_i,
  input  logic [decode_pkg::NR_LANES-1:0]                        fetch_valid_i,
  output logic [decode_pkg::NR_LANES-1:0]                        fetch_ready_o,
  input  logic [decode_pkg::NR_LANES-1:0]                        issue_ack_i,
  output logic [decode_pkg::NR_LANES-1:0]                        issue_valid_o,
  output decode_pkg::issue_entry_t [decode_pkg::NR_LANES-1:0]    issue_entry_o,
  output logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0]  orig_instr_o,
  output logic [decode_pkg::NR_LANES-1:0]                        is_ctrl_flow_o
);
  import decode_pkg::*;

  fetch_lane_if   fetch_lanes [NR_LANES] ();
  decoded_lane_if dec_lanes   [NR_LANES] ();

  rvc_expander u_rvc_expander (
    .fetch_instr_i (fetch_instr_i),
    .fetch_pc_i    (fetch_pc_i),
    .lanes_o       (fetch_lanes)
  );

  // One decoder per issue lane
  for (genvar k = 0; k < NR_LANES; k++) begin : g_dec
    instr_decoder u_instr_decoder (
      .lane_i (fetch_lanes[k]),
      .dec_o  (dec_lanes[k])
    );
  end

  issue_register u_issue_register (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .dec_i          (dec_lanes),
    .issue_ack_i    (issue_ack_i),
    .issue_valid_o  (issue_valid_o),
    .issue_entry_o  (issue_entry_o),
    .orig_instr_o   (orig_instr_o),
    .is_ctrl_flow_o (is_ctrl_flow_o)
  );

endmodule

//--- issue_register.sv
// ID/issue register
// Two slots kept in program order, filled from fetch and drained by issue

`timescale 1ns/1ns

module issue_register (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   flush_i,
  input  logic [decode_pkg::NR_LANES-1:0]                        fetch_valid_i,
  output logic [decode_pkg::NR_LANES-1:0]                        fetch_ready_o,
  decoded_lane_if.sink                                           dec_i [decode_pkg::NR_LANES],
  input  logic [decode_pkg::NR_LANES-1:0]                        issue_ack_i,
  output logic [decode_pkg::NR_LANES-1:0]                        issue_valid_o,
  output decode_pkg::issue_entry_t [decode_pkg::NR_LANES-1:0]    issue_entry_o,
  output logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0]  orig_instr_o,
  output logic [decode_pkg::NR_LANES-1:0]                        is_ctrl_flow_o
);
  import decode_pkg::*;

  typedef struct packed {
    issue_entry_t    entry;
    logic [XLEN-1:0] orig_instr;
    logic            is_ctrl_flow;
  } slot_t;

  slot_t [NR_LANES-1:0] lane_in;
  slot_t [NR_LANES-1:0] slot_d;
  slot_t [NR_LANES-1:0] slot_q;
  logic  [NR_LANES-1:0] valid_d;
  logic  [NR_LANES-1:0] valid_q;
  logic  [NR_LANES-1:0] held;
  logic  [NR_LANES-1:0] accept;
  // Keeps fetch_ready_o low until the first edge after reset
  logic                 active_q;

  for (genvar k = 0; k < NR_LANES; k++) begin : g_lane
    assign lane_in[k].entry        = dec_i[k].entry;
    assign lane_in[k].orig_instr   = dec_i[k].orig_instr;
    assign lane_in[k].is_ctrl_flow = dec_i[k].is_ctrl_flow;

    assign issue_entry_o[k]  = slot_q[k].entry;
    assign orig_instr_o[k]   = slot_q[k].orig_instr;
    assign is_ctrl_flow_o[k] = slot_q[k].is_ctrl_flow;
  end

  assign issue_valid_o = valid_q;

  // ----------------------------------------------------------------------
  // Drain, compact, then fill
  // ----------------------------------------------------------------------
  always_comb begin
    slot_d = slot_q;
    held   = valid_q & ~issue_ack_i;

    // Slot 1 moves down so slot 0 always holds the oldest entry
    if (!held[0] && held[1]) begin
      slot_d[0] = slot_q[1];
      held      = 2'b01;
    end

    fetch_ready_o[0] = active_q & ~flush_i & ~held[1];
    fetch_ready_o[1] = active_q & ~flush_i & ~held[0];
    accept           = fetch_valid_i & fetch_ready_o;

    valid_d = held;
    if (accept[0]) begin
      if (!held[0]) begin
        slot_d[0]  = lane_in[0];
        valid_d[0] = 1'b1;
      end else begin
        slot_d[1]  = lane_in[0];
        valid_d[1] = 1'b1;
      end
    end
    // Lane 1 comes only with lane 0, so slot 0 was free as well
    if (accept[1]) begin
      slot_d[1]  = lane_in[1];
      valid_d[1] = 1'b1;
    end

    if (flush_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      active_q <= 1'b0;
    end else begin
      valid_q  <= valid_d;
      active_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    slot_q <= slot_d;
  end

endmodule

//--- instr_decoder.sv
// RV32I instruction decoder for one lane
// Maps an expanded word to functional unit, operation, registers and immediate

`timescale 1ns/1ns

module instr_decoder (
  fetch_lane_if.sink     lane_i,
  decoded_lane_if.source dec_o
);
  import decode_pkg::*;

  logic [XLEN-1:0] instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  issue_entry_t    entry;
  logic            bad_enc;
  logic            ctrl_flow;

  // Shared by OP and OP-IMM, alt selects SUB or SRA
  function automatic fu_op_t alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? OP_SUB : OP_ADD;
      3'b001:  return OP_SLL;
      3'b010:  return OP_SLT;
      3'b011:  return OP_SLTU;
      3'b100:  return OP_XOR;
      3'b101:  return alt ? OP_SRA : OP_SRL;
      3'b110:  return OP_OR;
      default: return OP_AND;
    endcase
  endfunction

  assign instr  = lane_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    entry         = '0;
    entry.pc      = lane_i.pc;
    entry.fu      = FU_NONE;
    entry.op      = OP_ADD;
    entry.rs1     = instr[19:15];
    entry.rs2     = instr[24:20];
    entry.rd      = instr[11:7];
    bad_enc       = 1'b0;
    ctrl_flow     = 1'b0;

    case (opcode)
      OPC_OP: begin
        entry.fu = FU_ALU;
        entry.op = alu_op(funct3, funct7[5]);
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          bad_enc = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        entry.fu      = FU_ALU;
        entry.op      = alu_op(funct3, funct3 == 3'b101 && funct7[5]);
        entry.rs2     = '0;
        entry.imm     = imm_i;
        entry.use_imm = 1'b1;
        // Shift immediates only allow the SRAI pattern in the upper bits
        if ((funct3 == 3'b001 && funct7 != 7'b0000000) ||
            (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)) begin
          bad_enc = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        entry.fu      = FU_ALU;
        entry.op      = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
        entry.rs1     = '0;
        entry.rs2     = '0;
        entry.imm     = imm_u;
        entry.use_imm = 1'b1;
      end
      OPC_JAL: begin
        entry.fu      = FU_BRANCH;
        entry.op      = OP_JAL;
        entry.rs1     = '0;
        entry.rs2     = '0;
        entry.imm     = imm_j;
        entry.use_imm = 1'b1;
        ctrl_flow     = 1'b1;
      end
      OPC_JALR: begin
        entry.fu      = FU_BRANCH;
        entry.op      = OP_JALR;
        entry.rs2     = '0;
        entry.imm     = imm_i;
        entry.use_imm = 1'b1;
        ctrl_flow     = 1'b1;
        bad_enc       = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        entry.fu  = FU_BRANCH;
        entry.rd  = '0;
        entry.imm = imm_b;
        ctrl_flow = 1'b1;
        case (funct3)
          3'b000:  entry.op = OP_BEQ;
          3'b001:  entry.op = OP_BNE;
          3'b100:  entry.op = OP_BLT;
          3'b101:  entry.op = OP_BGE;
          3'b110:  entry.op = OP_BLTU;
          3'b111:  entry.op = OP_BGEU;
          default: bad_enc = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        // Word access only
        entry.fu      = FU_LSU;
        entry.use_imm = 1'b1;
        bad_enc       = (funct3 != 3'b010);
        if (opcode == OPC_LOAD) begin
          entry.op  = OP_LW;
          entry.rs2 = '0;
          entry.imm = imm_i;
        end else begin
          entry.op  = OP_SW;
          entry.rd  = '0;
          entry.imm = imm_s;
        end
      end
      default: bad_enc = 1'b1;
    endcase

    entry.is_compressed = lane_i.is_compressed;
    entry.illegal       = lane_i.illegal | bad_enc;
    if (entry.illegal) begin
      entry.fu  = FU_NONE;
      ctrl_flow = 1'b0;
    end
  end

  assign dec_o.entry        = entry;
  assign dec_o.orig_instr   = lane_i.orig_instr;
  assign dec_o.is_ctrl_flow = ctrl_flow;

endmodule

//--- rvc_expander.sv
// RVC expander
// Detects 16-bit compressed words on every lane and rebuilds the
// equivalent RV32I encoding for the supported subset

`timescale 1ns/1ns

module rvc_expander (
  input  logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0] fetch_instr_i,
  input  logic [decode_pkg::NR_LANES-1:0][decode_pkg::XLEN-1:0] fetch_pc_i,
  fetch_lane_if.source                                          lanes_o [decode_pkg::NR_LANES]
);
  import decode_pkg::*;

  // Returns {illegal, expanded word}
  function automatic logic [XLEN:0] expand_rvc(input logic [15:0] c);
    logic [XLEN-1:0] w;
    logic            bad;
    w   = '0;
    bad = 1'b0;
    case ({c[1:0], c[15:13]})
      // C.LW
      5'b00_010: w = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                      2'b01, c[4:2], OPC_LOAD};
      // C.SW
      5'b00_110: w = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                      c[11:10], c[6], 2'b00, OPC_STORE};
      // C.ADDI
      5'b01_000: w = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP_IMM};
      // C.LI
      5'b01_010: w = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7], OPC_OP_IMM};
      5'b01_011: begin
        // rd == x2 is C.ADDI16SP, a zero immediate is reserved
        if (c[11:7] == 5'd2 || {c[12], c[6:2]} == 6'd0) begin
          bad = 1'b1;
        end else begin
          w = {{15{c[12]}}, c[6:2], c[11:7], OPC_LUI};
        end
      end
      // C.J
      5'b01_101: w = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                      c[12], {8{c[12]}}, 5'b0, OPC_JAL};
      // C.BEQZ and C.BNEZ, funct3 bit 0 picks bne
      5'b01_110, 5'b01_111: w = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7],
                                 2'b00, c[13], c[11:10], c[4:3], c[12], OPC_BRANCH};
      5'b10_100: begin
        // rs2 == x0 selects C.JR, C.JALR or C.EBREAK
        if (c[6:2] == 5'd0) begin
          bad = 1'b1;
        end else if (c[12]) begin
          w = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP};
        end else begin
          w = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], OPC_OP};
        end
      end
      // Includes the all-zero word
      default: bad = 1'b1;
    endcase
    return {bad, w};
  endfunction

  for (genvar k = 0; k < NR_LANES; k++) begin : g_lane
    logic            compressed;
    logic [XLEN:0]   expanded;

    assign compressed = (fetch_instr_i[k][1:0] != 2'b11);
    assign expanded   = expand_rvc(fetch_instr_i[k][15:0]);

    assign lanes_o[k].is_compressed = compressed;
    assign lanes_o[k].instr         = compressed ? expanded[XLEN-1:0] : fetch_instr_i[k];
    assign lanes_o[k].illegal       = compressed & expanded[XLEN];
    assign lanes_o[k].pc            = fetch_pc_i[k];
    assign lanes_o[k].orig_instr    = compressed ? {16'b0, fetch_instr_i[k][15:0]}
                                                 : fetch_instr_i[k];
  end

endmodule

//--- decode_lane_if.sv
// Per-lane connections inside the decode stage
// Expanded words from the RVC expander and decoded entries for issue

`timescale 1ns/1ns

interface fetch_lane_if;
  import decode_pkg::*;

  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] pc;
  logic            is_compressed;
  logic            illegal;
  // Fetched word as it arrived, upper half cleared for compressed words
  logic [XLEN-1:0] orig_instr;

  modport source (output instr, pc, is_compressed, illegal, orig_instr);
  modport sink   (input  instr, pc, is_compressed, illegal, orig_instr);
endinterface

interface decoded_lane_if;
  import decode_pkg::*;

  issue_entry_t    entry;
  logic [XLEN-1:0] orig_instr;
  logic            is_ctrl_flow;

  modport source (output entry, orig_instr, is_ctrl_flow);
  modport sink   (input  entry, orig_instr, is_ctrl_flow);
endinterface

//--- decode_pkg.sv
// Decode stage package
// Lane count, data width, opcode, functional unit and operation encodings,
// and the decoded entry handed to issue

package decode_pkg;

  localparam int unsigned NR_LANES = 2;
  localparam int unsigned XLEN     = 32;

  // RV32I major opcodes handled by the decoders
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LSU
  } fu_t;

  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LW, OP_SW
  } fu_op_t;

  // Decoded instruction as it waits in the ID/issue register
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fu_t             fu;
    fu_op_t          op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            is_compressed;
    logic            illegal;
  } issue_entry_t;

endpackage
